/* logic/gpu_pkg.sv */
package gpu_pkg;

	// command opcodes, carried in bits 26:24 of the command word
	typedef enum logic [2:0]
	{
		OP_CLEAR      = 3'd0,
		OP_SET_START  = 3'd1,
		OP_SET_END    = 3'd2,
		OP_SET_COLOR  = 3'd3,
		OP_MOVE_START = 3'd4,
		OP_MOVE_END   = 3'd5,
		OP_DRAW       = 3'd6,
		OP_FLIP       = 3'd7
	} gpu_op_e;

	// kind of job handed to the rasteriser
	typedef enum logic
	{
		JOB_LINE  = 1'b0,
		JOB_CLEAR = 1'b1
	} job_e;

	// rasteriser FSM
	typedef enum logic [1:0]
	{
		IDLE  = 2'd0,
		LINE  = 2'd1,
		CLEAR = 2'd2
	} raster_state_e;

	localparam int X_W      = 9;
	localparam int Y_W      = 8;
	localparam int COLOR_W  = 24;
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;

endpackage

/* logic/draw_cmd_if.sv */
`timescale 1ns/1ps

// job request from the command decoder to the rasteriser
interface draw_cmd_if;

	logic [gpu_pkg::X_W-1:0]     start_x;
	logic [gpu_pkg::Y_W-1:0]     start_y;
	logic [gpu_pkg::X_W-1:0]     end_x;
	logic [gpu_pkg::Y_W-1:0]     end_y;
	logic [gpu_pkg::COLOR_W-1:0] color;
	gpu_pkg::job_e               job;
	logic                        back;
	logic                        go;
	logic                        busy;

	modport decoder (output start_x, start_y, end_x, end_y, color, job, back, go,
		input busy);

	modport raster (input start_x, start_y, end_x, end_y, color, job, back, go,
		output busy);

endinterface

/* logic/pixel_if.sv */
`timescale 1ns/1ps

// single pixel stream, transfers when valid and not stall
interface pixel_if;

	logic [gpu_pkg::X_W-1:0]     x;
	logic [gpu_pkg::Y_W-1:0]     y;
	logic [gpu_pkg::COLOR_W-1:0] color;
	logic                        back;
	logic                        valid;
	logic                        stall;

	modport source (output x, y, color, back, valid, input stall);

	modport sink (input x, y, color, back, valid, output stall);

endinterface

/* logic/apb_cmd_decoder.sv */
`timescale 1ns/1ps

module apb_cmd_decoder (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic        pready,
	output logic [31:0] prdata,
	draw_cmd_if.decoder cmd
);

	gpu_pkg::gpu_op_e            op;
	logic [gpu_pkg::X_W-1:0]     arg_x;
	logic [gpu_pkg::Y_W-1:0]     arg_y;
	logic                        is_job;
	logic                        accept;

	// opcode in 26:24, point is x above y
	assign op     = gpu_pkg::gpu_op_e'(pwdata[26:24]);
	assign arg_x  = pwdata[gpu_pkg::Y_W +: gpu_pkg::X_W];
	assign arg_y  = pwdata[gpu_pkg::Y_W-1:0];
	assign is_job = (op == gpu_pkg::OP_CLEAR) || (op == gpu_pkg::OP_DRAW);

	// hold the access phase of a job until the rasteriser is free
	assign pready = !(psel && penable && pwrite && is_job && (cmd.busy || cmd.go));
	assign accept = psel && penable && pwrite && pready;

	// status, bit 0 busy and bit 1 back buffer
	assign prdata = {30'b0, cmd.back, cmd.busy | cmd.go};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cmd.start_x <= '0;
			cmd.start_y <= '0;
			cmd.end_x   <= '0;
			cmd.end_y   <= '0;
			cmd.color   <= '0;
			cmd.job     <= gpu_pkg::JOB_LINE;
			cmd.back    <= 1'b0;
			cmd.go      <= 1'b0;
		end
		else
		begin
			cmd.go <= 1'b0;
			if (accept)
			begin
				case (op)
					gpu_pkg::OP_SET_START:
					begin
						cmd.start_x <= arg_x;
						cmd.start_y <= arg_y;
					end
					gpu_pkg::OP_SET_END:
					begin
						cmd.end_x <= arg_x;
						cmd.end_y <= arg_y;
					end
					gpu_pkg::OP_SET_COLOR: cmd.color <= pwdata[gpu_pkg::COLOR_W-1:0];
					// moves wrap at the field width
					gpu_pkg::OP_MOVE_START:
					begin
						cmd.start_x <= cmd.start_x + arg_x;
						cmd.start_y <= cmd.start_y + arg_y;
					end
					gpu_pkg::OP_MOVE_END:
					begin
						cmd.end_x <= cmd.end_x + arg_x;
						cmd.end_y <= cmd.end_y + arg_y;
					end
					gpu_pkg::OP_FLIP: cmd.back <= ~cmd.back;
					gpu_pkg::OP_CLEAR, gpu_pkg::OP_DRAW:
					begin
						cmd.go  <= 1'b1;
						cmd.job <= (op == gpu_pkg::OP_CLEAR) ? gpu_pkg::JOB_CLEAR
							: gpu_pkg::JOB_LINE;
					end
				endcase
			end
		end
	end

endmodule

/* logic/line_rasterizer.sv */
`timescale 1ns/1ps

module line_rasterizer (
	input  logic       clk,
	input  logic       rst_n,
	draw_cmd_if.raster cmd,
	pixel_if.source    pix
);

	localparam logic [gpu_pkg::X_W-1:0] MAX_X = gpu_pkg::X_W'(gpu_pkg::SCREEN_W - 1);
	localparam logic [gpu_pkg::Y_W-1:0] MAX_Y = gpu_pkg::Y_W'(gpu_pkg::SCREEN_H - 1);

	gpu_pkg::raster_state_e      state;
	logic [gpu_pkg::X_W-1:0]     cur_x, end_x;
	logic [gpu_pkg::Y_W-1:0]     cur_y, end_y;
	logic [gpu_pkg::COLOR_W-1:0] color;
	logic                        back;
	logic signed [11:0]          ddx, ddy, adx, ady;
	logic signed [11:0]          dx, dy, err, e2;
	logic                        x_neg, y_neg;
	logic                        step_x, step_y;
	logic                        visible, advance, last;

	// deltas of the incoming job
	assign ddx = 12'(cmd.end_x) - 12'(cmd.start_x);
	assign ddy = 12'(cmd.end_y) - 12'(cmd.start_y);
	assign adx = ddx[11] ? -ddx : ddx;
	assign ady = ddy[11] ? -ddy : ddy;

	// bresenham decision, dy is kept negative
	assign e2     = err <<< 1;
	assign step_x = (e2 >= dy);
	assign step_y = (e2 <= dx);

	// off-screen points still take a cycle but are not emitted
	assign visible = (cur_x <= MAX_X) && (cur_y <= MAX_Y);
	assign advance = (state != gpu_pkg::IDLE) && !(visible && pix.stall);
	assign last    = (state == gpu_pkg::LINE) ? (cur_x == end_x && cur_y == end_y)
		: (cur_x == MAX_X && cur_y == MAX_Y);

	assign cmd.busy  = (state != gpu_pkg::IDLE);
	assign pix.valid = (state != gpu_pkg::IDLE) && visible;
	assign pix.x     = cur_x;
	assign pix.y     = cur_y;
	assign pix.color = color;
	assign pix.back  = back;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= gpu_pkg::IDLE;
			cur_x <= '0;
			cur_y <= '0;
			end_x <= '0;
			end_y <= '0;
			color <= '0;
			back  <= 1'b0;
			dx    <= '0;
			dy    <= '0;
			err   <= '0;
			x_neg <= 1'b0;
			y_neg <= 1'b0;
		end
		else
		begin
			case (state)
				gpu_pkg::IDLE:
				begin
					if (cmd.go)
					begin
						end_x <= cmd.end_x;
						end_y <= cmd.end_y;
						color <= cmd.color;
						back  <= cmd.back;
						dx    <= adx;
						dy    <= -ady;
						err   <= adx - ady;
						x_neg <= ddx[11];
						y_neg <= ddy[11];
						if (cmd.job == gpu_pkg::JOB_CLEAR)
						begin
							cur_x <= '0;
							cur_y <= '0;
							state <= gpu_pkg::CLEAR;
						end
						else
						begin
							cur_x <= cmd.start_x;
							cur_y <= cmd.start_y;
							state <= gpu_pkg::LINE;
						end
					end
				end
				gpu_pkg::LINE:
				begin
					if (advance && last)
						state <= gpu_pkg::IDLE;
					else if (advance)
					begin
						if (step_x)
							cur_x <= x_neg ? cur_x - 1'b1 : cur_x + 1'b1;
						if (step_y)
							cur_y <= y_neg ? cur_y - 1'b1 : cur_y + 1'b1;
						err <= err + (step_x ? dy : 12'sd0) + (step_y ? dx : 12'sd0);
					end
				end
				gpu_pkg::CLEAR:
				begin
					// row by row over the whole buffer
					if (advance && last)
						state <= gpu_pkg::IDLE;
					else if (advance && cur_x == MAX_X)
					begin
						cur_x <= '0;
						cur_y <= cur_y + 1'b1;
					end
					else if (advance)
						cur_x <= cur_x + 1'b1;
				end
				default: state <= gpu_pkg::IDLE;
			endcase
		end
	end

endmodule

/* logic/ahb_pixel_writer.sv */
`timescale 1ns/1ps

module ahb_pixel_writer #(
	parameter logic [31:0] FB_BASE = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	pixel_if.sink       pix,
	output logic [31:0] haddr,
	output logic [31:0] hwdata,
	output logic        hwrite,
	output logic [1:0]  htrans,
	input  logic        hready
);

	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

	logic [31:0] row;
	logic [31:0] addr;
	logic        accept;

	// back buffer sits below the front one
	assign row  = 32'(pix.y) + (pix.back ? 32'(gpu_pkg::SCREEN_H) : 32'd0);
	assign addr = FB_BASE + ((row * 32'(gpu_pkg::SCREEN_W) + 32'(pix.x)) << 2);

	assign pix.stall = (htrans == HTRANS_NONSEQ) && !hready;
	assign accept    = pix.valid && !pix.stall;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			haddr  <= '0;
			hwdata <= '0;
			hwrite <= 1'b0;
			htrans <= HTRANS_IDLE;
		end
		else if (accept)
		begin
			haddr  <= addr;
			hwdata <= 32'(pix.color);
			hwrite <= 1'b1;
			htrans <= HTRANS_NONSEQ;
		end
		// write done and nothing behind it
		else if (hready)
		begin
			hwrite <= 1'b0;
			htrans <= HTRANS_IDLE;
		end
	end

endmodule

/* logic/gpu_top.sv */
`timescale 1ns/1ps

module gpu_top #(
	parameter logic [31:0] FB_BASE = 32'h0
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [31:0] pwdata,
	output logic        pready,
	output logic [31:0] prdata,
	output logic [31:0] haddr,
	output logic [31:0] hwdata,
	output logic        hwrite,
	output logic [1:0]  htrans,
	input  logic        hready
);

	draw_cmd_if cmd_bus ();
	pixel_if    pix_bus ();

	apb_cmd_decoder u_decoder (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.pready  (pready),
		.prdata  (prdata),
		.cmd     (cmd_bus.decoder)
	);

	line_rasterizer u_raster (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (cmd_bus.raster),
		.pix   (pix_bus.source)
	);

	ahb_pixel_writer #(.FB_BASE(FB_BASE)) u_writer (
		.clk    (clk),
		.rst_n  (rst_n),
		.pix    (pix_bus.sink),
		.haddr  (haddr),
		.hwdata (hwdata),
		.hwrite (hwrite),
		.htrans (htrans),
		.hready (hready)
	);

endmodule

/* sim/gpu_assertions.sv */
`timescale 1ns/1ps

// bus protocol checks on the top level ports
module gpu_assertions #(
	parameter logic [31:0] FB_BASE = 32'h0
) (
	input logic        clk,
	input logic        rst_n,
	input logic        psel,
	input logic        penable,
	input logic        pready,
	input logic [31:0] haddr,
	input logic [31:0] hwdata,
	input logic [1:0]  htrans,
	input logic        hready
);

	// both buffers, four bytes per pixel
	localparam logic [31:0] FB_BYTES = 32'(4 * gpu_pkg::SCREEN_W * 2 * gpu_pkg::SCREEN_H);

	// a stalled write keeps address and data
	hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans == 2'b10 && !hready) |=> ($stable(haddr) && $stable(hwdata)))
		else $error("AHB write changed while hready was low");

	ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		!pready |-> (psel && penable))
		else $error("pready low outside an APB access phase");

	addr_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans == 2'b10) |-> (haddr >= FB_BASE && haddr < FB_BASE + FB_BYTES))
		else $error("AHB address outside the frame buffer");

endmodule

bind gpu_top gpu_assertions #(.FB_BASE(FB_BASE)) u_assertions (
	.clk     (clk),
	.rst_n   (rst_n),
	.psel    (psel),
	.penable (penable),
	.pready  (pready),
	.haddr   (haddr),
	.hwdata  (hwdata),
	.htrans  (htrans),
	.hready  (hready)
);

/* sim/gpu_tb.sv */
`timescale 1ns/1ps

module gpu_tb;

	localparam logic [31:0] FB_BASE   = 32'h1000_0000;
	localparam int          PIX_BUF   = gpu_pkg::SCREEN_W * gpu_pkg::SCREEN_H;
	localparam int          APB_LIMIT = 400000;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic        pready;
	logic [31:0] prdata;
	logic [31:0] haddr;
	logic [31:0] hwdata;
	logic        hwrite;
	logic [1:0]  htrans;
	logic        hready;

	// frame buffer seen on the bus and the one the model predicts
	logic [gpu_pkg::COLOR_W-1:0] fb [int];
	logic [gpu_pkg::COLOR_W-1:0] exp_fb [int];
	int                          writes;
	int                          exp_writes;
	int                          errors;
	int                          tests;
	int                          held;
	integer                      seed;
	logic                        random_hready;
	logic [31:0]                 rnd;
	// model copy of the engine registers
	logic [gpu_pkg::X_W-1:0]     sx, ex;
	logic [gpu_pkg::Y_W-1:0]     sy, ey;
	logic [gpu_pkg::COLOR_W-1:0] col;
	logic                        bank;

	gpu_top #(.FB_BASE(FB_BASE)) dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// hready either always high or ready about three cycles in four
	always @(posedge clk)
	begin
		#1;
		rnd = $random(seed);
		hready = !random_hready || (rnd[1:0] != 2'b00);
	end

	// one record per completed bus write
	always @(posedge clk)
	begin
		if (rst_n && htrans == 2'b10 && hready)
		begin
			if (!hwrite || haddr[1:0] != 2'b00 || haddr < FB_BASE
				|| ((haddr - FB_BASE) >> 2) >= 32'(2 * PIX_BUF)
				|| hwdata[31:gpu_pkg::COLOR_W] != '0)
			begin
				$display("** Error at %0t: bad AHB write of %h to %h",
					$time, hwdata, haddr);
				errors++;
			end
			else
				fb[int'((haddr - FB_BASE) >> 2)] = hwdata[gpu_pkg::COLOR_W-1:0];
			writes++;
		end
	end

	initial
	begin
		#20_000_000;
		$display("watchdog expired before the tests completed");
		$display("Regression failed");
		$finish;
	end

	function automatic logic [23:0] pt(input int x, input int y);
		return {7'b0, gpu_pkg::X_W'(x), gpu_pkg::Y_W'(y)};
	endfunction

	task automatic apb_access(input logic write, input logic [31:0] data,
		output logic [31:0] rdata);
		int waited;
		waited  = 0;
		psel    = 1'b1;
		pwrite  = write;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk);
		while (!pready && waited < APB_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		rdata = prdata;
		held  = waited;
		if (!pready)
		begin
			$display("APB transfer timed out, pready stayed low for %0d cycles", waited);
			errors++;
		end
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] data);
		logic [31:0] unused;
		apb_access(1'b1, data, unused);
	endtask

	task automatic apb_read(output logic [31:0] data);
		apb_access(1'b0, 32'h0, data);
	endtask

	task automatic plot(input int x, input int y);
		if (x < gpu_pkg::SCREEN_W && y < gpu_pkg::SCREEN_H)
		begin
			exp_fb[int'(bank) * PIX_BUF + y * gpu_pkg::SCREEN_W + x] = col;
			exp_writes++;
		end
	endtask

	// integer bresenham from start to end inclusive
	task automatic expected_line();
		int x, y, dx, dy, stx, sty, err, e2;
		logic done;
		x    = sx;
		y    = sy;
		dx   = int'(ex) - int'(sx);
		dy   = int'(ey) - int'(sy);
		stx  = (dx < 0) ? -1 : 1;
		sty  = (dy < 0) ? -1 : 1;
		dx   = (dx < 0) ? -dx : dx;
		dy   = (dy < 0) ? dy : -dy;
		err  = dx + dy;
		done = 1'b0;
		while (!done)
		begin
			plot(x, y);
			if (x == int'(ex) && y == int'(ey))
				done = 1'b1;
			else
			begin
				e2 = 2 * err;
				if (e2 >= dy)
				begin
					err += dy;
					x   += stx;
				end
				if (e2 <= dx)
				begin
					err += dx;
					y   += sty;
				end
			end
		end
	endtask

	task automatic expected_clear();
		for (int k = 0; k < PIX_BUF; k++)
			exp_fb[int'(bank) * PIX_BUF + k] = col;
		exp_writes += PIX_BUF;
	endtask

	// issue one command and update the model
	task automatic send(input gpu_pkg::gpu_op_e op, input logic [23:0] data);
		logic [gpu_pkg::X_W-1:0] ax;
		logic [gpu_pkg::Y_W-1:0] ay;
		apb_write({5'b0, op, data});
		ax = data[16:8];
		ay = data[7:0];
		case (op)
			gpu_pkg::OP_SET_START:
			begin
				sx = ax;
				sy = ay;
			end
			gpu_pkg::OP_SET_END:
			begin
				ex = ax;
				ey = ay;
			end
			gpu_pkg::OP_SET_COLOR: col = data;
			// wraps at the field width
			gpu_pkg::OP_MOVE_START:
			begin
				sx = sx + ax;
				sy = sy + ay;
			end
			gpu_pkg::OP_MOVE_END:
			begin
				ex = ex + ax;
				ey = ey + ay;
			end
			gpu_pkg::OP_FLIP: bank = !bank;
			gpu_pkg::OP_DRAW: expected_line();
			default: expected_clear();
		endcase
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		int polls;
		polls  = 0;
		status = 32'h1;
		while (status[0] && polls < 200000)
		begin
			apb_read(status);
			polls++;
		end
		// the last pixel may still sit on the bus
		polls = 0;
		while (htrans != 2'b00 && polls < 1000)
		begin
			@(posedge clk);
			#1;
			polls++;
		end
		if (status[0] || htrans != 2'b00)
		begin
			$display("engine did not go idle before the timeout");
			errors++;
		end
	endtask

	task automatic check_pixel(input logic b, input logic [gpu_pkg::X_W-1:0] x,
		input logic [gpu_pkg::Y_W-1:0] y, input logic [gpu_pkg::COLOR_W-1:0] color);
		int k;
		k = int'(b) * PIX_BUF + int'(y) * gpu_pkg::SCREEN_W + int'(x);
		if (!fb.exists(k))
		begin
			$display("** Error at %0t: pixel (%0d,%0d) buffer %0b never written",
				$time, x, y, b);
			errors++;
		end
		else if (fb[k] !== color)
		begin
			$display("** Error at %0t: pixel (%0d,%0d) buffer %0b is %h, expected %h",
				$time, x, y, b, fb[k], color);
			errors++;
		end
	endtask

	task automatic check_status(input logic busy, input logic back);
		logic [31:0] status;
		apb_read(status);
		if (status !== {30'b0, back, busy})
		begin
			$display("** Error at %0t: status %h, expected busy %0b back %0b",
				$time, status, busy, back);
			errors++;
		end
	endtask

	task automatic check_op(input gpu_pkg::gpu_op_e op);
		if (writes != exp_writes)
		begin
			$display("** Error at %0t: after %s, %0d pixel writes, expected %0d",
				$time, op.name(), writes, exp_writes);
			errors++;
		end
	endtask

	task automatic compare_frame();
		if (fb.size() != exp_fb.size())
		begin
			$display("** Error at %0t: %0d distinct pixels written, expected %0d",
				$time, fb.size(), exp_fb.size());
			errors++;
		end
		foreach (exp_fb[k])
			check_pixel(k >= PIX_BUF, gpu_pkg::X_W'(k % PIX_BUF % gpu_pkg::SCREEN_W),
				gpu_pkg::Y_W'(k % PIX_BUF / gpu_pkg::SCREEN_W), exp_fb[k]);
	endtask

	task automatic draw_line(input int x0, input int y0, input int x1, input int y1,
		input logic [23:0] color);
		send(gpu_pkg::OP_SET_COLOR, color);
		send(gpu_pkg::OP_SET_START, pt(x0, y0));
		send(gpu_pkg::OP_SET_END, pt(x1, y1));
		send(gpu_pkg::OP_DRAW, 24'h0);
		wait_idle();
		check_op(gpu_pkg::OP_DRAW);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - errs_before);
	endtask

	initial
	begin
		int e0;
		seed          = 32'h6cb1_bb52;
		random_hready = 1'b0;
		hready        = 1'b1;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		pwdata        = 32'h0;
		sx            = '0;
		sy            = '0;
		ex            = '0;
		ey            = '0;
		col           = '0;
		bank          = 1'b0;
		rst_n         = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		e0 = errors;
		check_status(1'b0, 1'b0);
		send(gpu_pkg::OP_SET_START, pt(10, 20));
		send(gpu_pkg::OP_SET_END, pt(40, 20));
		send(gpu_pkg::OP_SET_COLOR, 24'h12_3456);
		check_op(gpu_pkg::OP_SET_COLOR);
		report_test("reset", e0);

		// horizontal, vertical, steep, reversed, single point
		e0 = errors;
		draw_line(10, 20, 40, 20, 24'hff_0000);
		draw_line(5, 5, 5, 60, 24'h00_ff00);
		draw_line(100, 10, 110, 90, 24'h00_00ff);
		draw_line(300, 200, 20, 150, 24'hab_cdef);
		draw_line(77, 77, 77, 77, 24'h55_aa55);
		compare_frame();
		check_status(1'b0, 1'b0);
		report_test("lines", e0);

		// start lands off-screen and end wraps to (9,9)
		e0 = errors;
		send(gpu_pkg::OP_SET_START, pt(300, 200));
		send(gpu_pkg::OP_MOVE_START, pt(30, 50));
		send(gpu_pkg::OP_SET_END, pt(10, 10));
		send(gpu_pkg::OP_MOVE_END, pt(511, 255));
		send(gpu_pkg::OP_DRAW, 24'h0);
		wait_idle();
		check_op(gpu_pkg::OP_DRAW);
		compare_frame();
		report_test("moves", e0);

		e0 = errors;
		send(gpu_pkg::OP_FLIP, 24'h0);
		check_status(1'b0, 1'b1);
		draw_line(0, 0, 319, 239, 24'h80_8080);
		compare_frame();
		send(gpu_pkg::OP_FLIP, 24'h0);
		check_status(1'b0, 1'b0);
		report_test("flip", e0);

		e0 = errors;
		send(gpu_pkg::OP_SET_COLOR, 24'h20_4060);
		send(gpu_pkg::OP_CLEAR, 24'h0);
		wait_idle();
		check_op(gpu_pkg::OP_CLEAR);
		compare_frame();
		report_test("clear", e0);

		// draw arrives while the clear still runs
		e0 = errors;
		random_hready = 1'b1;
		send(gpu_pkg::OP_SET_START, pt(319, 0));
		send(gpu_pkg::OP_SET_END, pt(0, 239));
		send(gpu_pkg::OP_SET_COLOR, 24'hc0_ffee);
		send(gpu_pkg::OP_CLEAR, 24'h0);
		send(gpu_pkg::OP_SET_COLOR, 24'h00_00ff);
		send(gpu_pkg::OP_DRAW, 24'h0);
		if (held == 0)
		begin
			$display("** Error at %0t: draw was accepted while the clear was busy", $time);
			errors++;
		end
		wait_idle();
		check_op(gpu_pkg::OP_DRAW);
		compare_frame();
		random_hready = 1'b0;
		report_test("stalls", e0);

		$display("%0d tests, %0d errors", tests, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* gpu_top.f */
logic/gpu_pkg.sv
logic/draw_cmd_if.sv
logic/pixel_if.sv
logic/apb_cmd_decoder.sv
logic/line_rasterizer.sv
logic/ahb_pixel_writer.sv
logic/gpu_top.sv
sim/gpu_assertions.sv
sim/gpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the gpu testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module gpu_tb -f gpu_top.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vgpu_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" "$log"; then
	exit 1
fi
exit 0
